// ==== include/stream_mem_params.svh ====
// stream memory parameters
// RAM geometry, register word size and streamer buffering
`ifndef STREAM_MEM_PARAMS_SVH
`define STREAM_MEM_PARAMS_SVH

//--------------------
// RAM geometry
//--------------------
`define STREAM_MEM_ADDR_W      12  // word address bits, 4096 words
`define STREAM_MEM_DATA_W      32  // word width
`define STREAM_MEM_BYTES       4   // bytes per word, one enable each

//--------------------
// control registers
//--------------------
`define STREAM_MEM_REG_W       16  // register word width
`define STREAM_MEM_REG_ADDR_W  2   // start, stop, run (run aliased at 3)

// words buffered between RAM and the byte serializer
`define STREAM_MEM_FIFO_DEPTH  4

`endif

// ==== logic/stream_mem_pkg.sv ====
// stream memory shared types
// host and register access structs, register word views, streamer links
`include "stream_mem_params.svh"

package stream_mem_pkg;

   typedef logic [`STREAM_MEM_ADDR_W-1:0] mem_addr_t;  // word address
   typedef logic [`STREAM_MEM_DATA_W-1:0] mem_word_t;  // RAM word
   typedef logic [`STREAM_MEM_BYTES-1:0]  byte_en_t;   // bit 3 is the top byte

   typedef struct packed {
      logic      wr_strobe;  // one cycle, no back-pressure
      logic      rd_strobe;
      mem_addr_t addr;
      mem_word_t wdata;
      byte_en_t  byte_en;
   } host_req_t;

   typedef struct packed {
      logic      rd_done;    // single pulse, rdata valid with it
      mem_word_t rdata;
   } host_rsp_t;

   // control view of a register word
   typedef struct packed {
      logic [`STREAM_MEM_REG_W-2:0] rsvd;
      logic                         run;
   } reg_ctrl_t;

   // one register word, read either as an address or as control bits
   typedef union packed {
      logic [`STREAM_MEM_REG_W-1:0] addr;  // only low address bits kept
      reg_ctrl_t                    ctrl;
   } reg_word_u;

   typedef struct packed {
      logic                              write;
      logic                              read;
      logic [`STREAM_MEM_REG_ADDR_W-1:0] addr;
      reg_word_u                         wdata;
   } reg_req_t;

   typedef struct packed {
      mem_addr_t start;
      mem_addr_t stop;
      logic      run;
   } stream_cfg_t;

   typedef struct packed {
      logic      req;
      mem_addr_t addr;
   } fetch_req_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } byte_out_t;

   // register map, run also answers at address 3
   typedef enum logic [`STREAM_MEM_REG_ADDR_W-1:0] {
      REG_START = 2'd0,
      REG_STOP  = 2'd1,
      REG_RUN   = 2'd2
   } reg_sel_e;

endpackage

// ==== logic/stream_regs.sv ====
// streamer control registers
// start and stop word addresses plus the run bit, with registered readback
`include "stream_mem_params.svh"

module stream_regs import stream_mem_pkg::*; (
   input  logic        clk,
   input  logic        reset_n,
   input  reg_req_t    regs,
   output reg_word_u   reg_rdata,
   output logic        reg_rvalid,
   output stream_cfg_t cfg
);

   localparam int ADDR_W = `STREAM_MEM_ADDR_W;
   localparam int REG_W  = `STREAM_MEM_REG_W;

   mem_addr_t start_addr;  // first word of the stream
   mem_addr_t stop_addr;   // last word before wrapping
   logic      run;
   reg_sel_e  sel;
   reg_word_u rd_mux;

   // fold address 3 onto the run register
   assign sel = regs.addr[1] ? REG_RUN : reg_sel_e'(regs.addr);

   //--------------------
   // register writes
   //--------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         start_addr <= '0;
         stop_addr  <= '0;
         run        <= 1'b0;
      end else if (regs.write) begin
         case (sel)
            REG_START: start_addr <= regs.wdata.addr[ADDR_W-1:0];  // upper bits dropped
            REG_STOP:  stop_addr  <= regs.wdata.addr[ADDR_W-1:0];
            REG_RUN:   run        <= regs.wdata.ctrl.run;
         endcase
      end
   end

   //--------------------
   // readback
   //--------------------
   always_comb begin
      rd_mux = '0;  // reserved bits read as zero
      case (sel)
         REG_START: rd_mux.addr     = {{(REG_W-ADDR_W){1'b0}}, start_addr};
         REG_STOP:  rd_mux.addr     = {{(REG_W-ADDR_W){1'b0}}, stop_addr};
         REG_RUN:   rd_mux.ctrl.run = run;
      endcase
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= regs.read;  // exactly one cycle after the strobe
      end
   end

   always_ff @(posedge clk) begin
      if (regs.read) begin
         reg_rdata <= rd_mux;
      end
   end

   // settings steer the streamer directly
   assign cfg = '{start: start_addr, stop: stop_addr, run: run};

endmodule

// ==== logic/mem_arbiter.sv ====
// word RAM with byte-enabled host writes
// one registered read port, streamer fetches take it ahead of host reads
`include "stream_mem_params.svh"

module mem_arbiter import stream_mem_pkg::*; (
   input  logic       clk,
   input  logic       reset_n,
   input  host_req_t  host,
   input  fetch_req_t fetch,
   output host_rsp_t  host_rsp,
   output logic       fetch_grant,
   output mem_word_t  rd_word
);

   localparam int DEPTH  = 2 ** `STREAM_MEM_ADDR_W;
   localparam int NBYTES = `STREAM_MEM_BYTES;

   mem_word_t ram [DEPTH];

   mem_addr_t host_addr_q;  // latched host read address
   logic      host_pend;    // host read waiting for a free read slot
   logic      host_serve;   // host read goes to the RAM this cycle
   logic      host_owner;   // word now on rd_word belongs to the host
   logic      rd_en;
   mem_addr_t rd_addr;

   //--------------------
   // write path
   //--------------------
   // host writes never wait, each enabled byte lands at the next edge
   always_ff @(posedge clk) begin
      if (host.wr_strobe) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (host.byte_en[b]) begin
               ram[host.addr][8*b +: 8] <= host.wdata[8*b +: 8];
            end
         end
      end
   end

   //--------------------
   // read arbitration
   //--------------------
   assign fetch_grant = fetch.req;                 // streamer always wins
   assign host_serve  = host_pend & ~fetch_grant;  // host only in an idle slot
   assign rd_en       = fetch_grant | host_serve;
   assign rd_addr     = fetch_grant ? fetch.addr : host_addr_q;

   // registered read, word shows up the cycle after the grant
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_word <= ram[rd_addr];
      end
   end

   // hold a host read until the streamer leaves a gap
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         host_pend  <= 1'b0;
         host_owner <= 1'b0;
      end else begin
         host_owner <= host_serve;  // tags the word returning next cycle
         if (host.rd_strobe) begin
            host_pend <= 1'b1;
         end else if (host_serve) begin
            host_pend <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (host.rd_strobe) begin
         host_addr_q <= host.addr;
      end
   end

   // streamer words also pass by here, rd_done marks only the host ones
   assign host_rsp.rd_done = host_owner;
   assign host_rsp.rdata   = rd_word;

endmodule

// ==== logic/byte_streamer.sv ====
// byte streamer
// walks start..stop with wrap, buffers words in a FIFO, sends bytes MSB first
`include "stream_mem_params.svh"

module byte_streamer import stream_mem_pkg::*; #(
   parameter int FIFO_DEPTH = `STREAM_MEM_FIFO_DEPTH  // power of two, 2 or more
) (
   input  logic        clk,
   input  logic        reset_n,
   input  stream_cfg_t cfg,
   input  logic        fetch_grant,
   input  mem_word_t   rd_word,
   input  logic        stream_ready,
   output fetch_req_t  fetch,
   output byte_out_t   stream
);

   localparam int PTR_W  = $clog2(FIFO_DEPTH);
   localparam int DATA_W = `STREAM_MEM_DATA_W;
   localparam int NBYTES = `STREAM_MEM_BYTES;
   localparam int CNT_W  = $clog2(NBYTES) + 1;

   // address walker
   mem_addr_t        walk_addr;  // next word to fetch
   logic             grant_q;    // fetch in flight, word on rd_word now
   logic [PTR_W+1:0] occupancy;  // stored words plus the one in flight

   // word FIFO
   mem_word_t        fifo_mem [FIFO_DEPTH];
   logic [PTR_W:0]   wr_ptr;     // extra bit tells full from empty
   logic [PTR_W:0]   rd_ptr;
   logic [PTR_W:0]   level;
   logic             fifo_empty;

   // byte serializer
   mem_word_t        sh_word;    // top byte is the one on the port
   logic [CNT_W-1:0] sh_cnt;     // bytes left in the shifter
   logic             sh_take;    // byte accepted by the sink
   logic             sh_load;    // refill shifter from the FIFO

   //--------------------
   // address walker
   //--------------------
   assign level     = wr_ptr - rd_ptr;
   assign occupancy = {1'b0, level} + {{(PTR_W+1){1'b0}}, grant_q};

   // ask only while a returning word is sure to find room
   assign fetch.req  = cfg.run & (occupancy < (PTR_W+2)'(FIFO_DEPTH));
   assign fetch.addr = walk_addr;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         walk_addr <= '0;
         grant_q   <= 1'b0;
      end else if (!cfg.run) begin
         walk_addr <= cfg.start;  // follows start while stopped
         grant_q   <= 1'b0;       // drop any word still on its way
      end else begin
         grant_q <= fetch.req & fetch_grant;
         if (fetch.req & fetch_grant) begin
            if (walk_addr < cfg.stop) begin
               walk_addr <= walk_addr + 1'b1;
            end else begin
               walk_addr <= cfg.start;  // wrap
            end
         end
      end
   end

   //--------------------
   // FIFO and shifter control
   //--------------------
   assign fifo_empty = (level == '0);
   assign sh_take    = stream.valid & stream_ready;

   // reload when empty, or as the last byte leaves, so bytes run gap free
   assign sh_load = ~fifo_empty &
                    ((sh_cnt == '0) | (sh_take & (sh_cnt == CNT_W'(1))));

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         sh_cnt <= '0;
      end else if (!cfg.run) begin
         wr_ptr <= '0;  // flush everything on stop
         rd_ptr <= '0;
         sh_cnt <= '0;
      end else begin
         if (grant_q) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (sh_load) begin
            rd_ptr <= rd_ptr + 1'b1;
            sh_cnt <= CNT_W'(NBYTES);
         end else if (sh_take) begin
            sh_cnt <= sh_cnt - 1'b1;
         end
      end
   end

   //--------------------
   // data path
   //--------------------
   always_ff @(posedge clk) begin
      if (grant_q) begin
         fifo_mem[wr_ptr[PTR_W-1:0]] <= rd_word;  // word granted last cycle
      end
      if (sh_load) begin
         sh_word <= fifo_mem[rd_ptr[PTR_W-1:0]];
      end else if (sh_take) begin
         sh_word <= {sh_word[DATA_W-9:0], 8'h00};  // next byte to the top
      end
   end

   // valid and data only move on a transfer or a reload from empty
   assign stream.valid = (sh_cnt != '0);
   assign stream.data  = sh_word[DATA_W-1:DATA_W-8];

endmodule

// ==== logic/stream_mem_top.sv ====
// stream memory top level
// host word port, control registers and the byte stream around one RAM
module stream_mem_top import stream_mem_pkg::*; (
   input  logic      clk,
   input  logic      reset_n,

   // host word access
   input  host_req_t host,
   output host_rsp_t host_rsp,

   // control registers
   input  reg_req_t  regs,
   output reg_word_u reg_rdata,
   output logic      reg_rvalid,

   // byte stream, valid/ready
   output byte_out_t stream,
   input  logic      stream_ready
);

   stream_cfg_t cfg;          // register settings to the streamer
   fetch_req_t  fetch;        // streamer read request
   logic        fetch_grant;
   mem_word_t   rd_word;      // shared RAM read data

   //--------------------
   // control registers
   //--------------------
   stream_regs stream_regs_inst (
      .clk        (clk),
      .reset_n    (reset_n),
      .regs       (regs),
      .reg_rdata  (reg_rdata),
      .reg_rvalid (reg_rvalid),
      .cfg        (cfg)
   );

   //--------------------
   // RAM and read port
   //--------------------
   mem_arbiter mem_arbiter_inst (
      .clk         (clk),
      .reset_n     (reset_n),
      .host        (host),
      .fetch       (fetch),
      .host_rsp    (host_rsp),
      .fetch_grant (fetch_grant),
      .rd_word     (rd_word)
   );

   //--------------------
   // streamer
   //--------------------
   byte_streamer byte_streamer_inst (
      .clk          (clk),
      .reset_n      (reset_n),
      .cfg          (cfg),
      .fetch_grant  (fetch_grant),
      .rd_word      (rd_word),
      .stream_ready (stream_ready),
      .fetch        (fetch),
      .stream       (stream)
   );

endmodule

// ==== testbench/tb_clock.sv ====
// testbench clock and reset source
// free running clock, reset held low for a fixed number of cycles
module tb_clock #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic reset_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);  // release away from the active edge
      reset_n = 1'b1;
   end

endmodule

// ==== testbench/stream_mem_tb.sv ====
// stream memory testbench
// table driven host, register and byte stream tests against a memory model
`include "stream_mem_params.svh"

module stream_mem_tb import stream_mem_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_STEPS    = 35;
   localparam int STEP_CYCLES  = 200;  // per step bound for the watchdog
   localparam int READ_LIMIT   = 100;  // cycles a host read may wait
   localparam int STALL_LIMIT  = 100;  // cycles without a byte while collecting
   localparam int WATCHDOG_NS  = (RESET_CYCLES + 16 + NUM_STEPS * STEP_CYCLES) * CLK_PERIOD;

   typedef enum logic [2:0] {
      HOST_WR,
      HOST_RD,
      REG_WR,
      REG_RD,
      STREAM_RUN,
      STREAM_STOP
   } step_kind_e;

   typedef struct packed {
      step_kind_e  kind;
      logic [15:0] addr;        // word, register or host read base address
      logic [31:0] wdata;
      logic        rand_data;   // write data from the LFSR
      logic [3:0]  byte_en;
      logic [15:0] exp;         // expected register readback
      logic [15:0] count;       // stream bytes to collect
      logic        rand_ready;
      logic        host_reads;  // host reads issued while streaming
   } step_t;

   logic      clk;
   logic      reset_n;
   host_req_t host;
   host_rsp_t host_rsp;
   reg_req_t  regs;
   reg_word_u reg_rdata;
   logic      reg_rvalid;
   byte_out_t stream;
   logic      stream_ready;

   step_t       steps [NUM_STEPS];
   mem_word_t   model_mem [1 << `STREAM_MEM_ADDR_W];
   mem_addr_t   model_start;
   mem_addr_t   model_stop;
   logic        model_run;
   int          stream_index;   // byte k of the current run
   logic [31:0] lfsr_state;

   tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) tb_clock_inst (
      .clk     (clk),
      .reset_n (reset_n)
   );

   stream_mem_top stream_mem_top_inst (
      .clk          (clk),
      .reset_n      (reset_n),
      .host         (host),
      .host_rsp     (host_rsp),
      .regs         (regs),
      .reg_rdata    (reg_rdata),
      .reg_rvalid   (reg_rvalid),
      .stream       (stream),
      .stream_ready (stream_ready)
   );

   //--------------------
   // random source
   //--------------------
   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         bits = {bits[30:0], lfsr_state[0]};  // one step per bit
      end
      return bits;
   endfunction

   //--------------------
   // reference model
   //--------------------
   function automatic mem_word_t merge_bytes(input mem_word_t old_w, input mem_word_t new_w,
                                             input byte_en_t en);
      mem_word_t res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (en[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   // byte k is lane 3 - k mod 4 of word start + k div 4 with wrap after stop
   function automatic logic [7:0] expected_byte(input int k);
      int span;
      int word_addr;
      int lane;
      span      = int'(model_stop) - int'(model_start) + 1;
      word_addr = int'(model_start) + (k / 4) % span;
      lane      = 3 - (k % 4);
      return model_mem[word_addr][8*lane +: 8];
   endfunction

   //--------------------
   // checks
   //--------------------
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic compare_word(input string name, input mem_word_t got, input mem_word_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("[FAIL] t=%0d ns %s got %08h expected %08h",
                                 $time, name, got, exp));
      end
   endtask

   task automatic check_reg_word(input string name, input reg_word_u got, input reg_word_u exp);
      if (got !== exp) begin
         stop_on_error($sformatf("[FAIL] t=%0d ns %s got %04h expected %04h",
                                 $time, name, got, exp));
      end
   endtask

   task automatic verify_stream_byte(input string name, input logic [7:0] got,
                                     input logic [7:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("[FAIL] t=%0d ns %s got %02h expected %02h",
                                 $time, name, got, exp));
      end
   endtask

   //--------------------
   // bus actions driven on the falling edge
   //--------------------
   task automatic host_write(input mem_addr_t addr, input mem_word_t data, input byte_en_t en);
      @(negedge clk);
      host.wr_strobe = 1'b1;
      host.addr      = addr;
      host.wdata     = data;
      host.byte_en   = en;
      @(negedge clk);
      host.wr_strobe = 1'b0;
      model_mem[addr] = merge_bytes(model_mem[addr], data, en);
   endtask

   task automatic host_read(input mem_addr_t addr);
      int waited;
      waited = 0;
      @(negedge clk);
      host.rd_strobe = 1'b1;
      host.addr      = addr;
      @(negedge clk);
      host.rd_strobe = 1'b0;
      while (host_rsp.rd_done !== 1'b1) begin  // latency varies with fetch traffic
         if (waited >= READ_LIMIT) begin
            stop_on_error($sformatf("host read of word %0d never returned rd_done", addr));
         end
         @(negedge clk);
         waited++;
      end
      compare_word($sformatf("host_rsp.rdata[%0d]", addr), host_rsp.rdata, model_mem[addr]);
   endtask

   task automatic reg_write(input logic [1:0] addr, input logic [15:0] data);
      @(negedge clk);
      regs.write = 1'b1;
      regs.addr  = addr;
      regs.wdata = data;
      @(negedge clk);
      regs.write = 1'b0;
      if (addr[1]) begin                        // run register answers at 2 and 3
         if (data[0] && !model_run) stream_index = 0;  // run restarts at start
         model_run = data[0];
      end else if (addr[0]) begin
         model_stop = data[`STREAM_MEM_ADDR_W-1:0];
      end else begin
         model_start = data[`STREAM_MEM_ADDR_W-1:0];
      end
   endtask

   task automatic reg_read(input logic [1:0] addr, input logic [15:0] exp);
      @(negedge clk);
      regs.read = 1'b1;
      regs.addr = addr;
      if (reg_rvalid !== 1'b0) stop_on_error("reg_rvalid high before the read strobe");
      @(negedge clk);
      regs.read = 1'b0;
      if (reg_rvalid !== 1'b1) stop_on_error("reg_rvalid missing one cycle after the strobe");
      check_reg_word(addr[1] ? "reg_rdata.ctrl" : "reg_rdata.addr", reg_rdata, exp);
      @(negedge clk);
      if (reg_rvalid !== 1'b0) stop_on_error("reg_rvalid held longer than one cycle");
   endtask

   // collect bytes with optional random ready and host reads in between
   task automatic collect_stream(input int count, input logic rand_ready, input logic reads,
                                 input mem_addr_t base);
      int        k_end;
      int        idle;
      int        rd_wait;
      int        rd_count;
      logic      rd_busy;
      logic      prev_stall;
      logic [7:0] prev_data;
      mem_addr_t rd_addr;
      k_end      = stream_index + count;
      idle       = 0;
      rd_wait    = 0;
      rd_count   = 0;
      rd_busy    = 1'b0;
      prev_stall = 1'b0;
      prev_data  = '0;
      rd_addr    = base;
      while (stream_index < k_end || rd_busy) begin
         @(negedge clk);
         host.rd_strobe = 1'b0;
         if (rd_busy && host_rsp.rd_done === 1'b1) begin
            compare_word($sformatf("host_rsp.rdata[%0d]", rd_addr), host_rsp.rdata,
                         model_mem[rd_addr]);
            rd_busy = 1'b0;
         end else if (rd_busy) begin
            rd_wait++;
            if (rd_wait > READ_LIMIT) begin
               stop_on_error("host read issued during streaming never completed");
            end
         end else if (host_rsp.rd_done !== 1'b0) begin
            stop_on_error("rd_done pulsed with no host read outstanding");
         end
         if (reads && !rd_busy && stream_index < k_end && take_bits(2) == 0) begin
            rd_addr        = base + mem_addr_t'(rd_count % 3);
            host.rd_strobe = 1'b1;
            host.addr      = rd_addr;
            rd_busy        = 1'b1;
            rd_wait        = 0;
            rd_count++;
         end
         if (prev_stall) begin  // sink stalled last cycle so the byte must hold
            if (stream.valid !== 1'b1) stop_on_error("stream valid dropped while ready was low");
            verify_stream_byte("stream.data held", stream.data, prev_data);
         end
         if (stream_index < k_end) begin
            stream_ready = rand_ready ? take_bits(1) : 1'b1;
         end else begin
            stream_ready = 1'b0;
         end
         if (stream.valid === 1'b1 && stream_ready) begin
            verify_stream_byte($sformatf("stream.data[%0d]", stream_index), stream.data,
                               expected_byte(stream_index));
            stream_index++;
            idle = 0;
         end else if (stream_index < k_end) begin
            idle++;
            if (idle > STALL_LIMIT) begin
               stop_on_error("no stream byte arrived while collecting");
            end
         end
         prev_stall = stream.valid && !stream_ready;
         prev_data  = stream.data;
      end
      @(negedge clk);
      stream_ready = 1'b0;  // no transfers between steps
   endtask

   // clear run and see valid fall within two edges and stay low
   task automatic stop_stream();
      reg_write(2'd2, 16'h0000);
      for (int c = 0; c < 4; c++) begin
         @(negedge clk);
         if (stream.valid !== 1'b0) stop_on_error("stream valid still high after run was cleared");
      end
   endtask

   task automatic run_step(input step_t s);
      mem_word_t data;
      data = s.wdata;
      if (s.rand_data) data = take_bits(32);
      case (s.kind)
         HOST_WR:     host_write(mem_addr_t'(s.addr), data, s.byte_en);
         HOST_RD:     host_read(mem_addr_t'(s.addr));
         REG_WR:      reg_write(s.addr[1:0], s.wdata[15:0]);
         REG_RD:      reg_read(s.addr[1:0], s.exp);
         STREAM_RUN: begin
            if (!model_run) reg_write(2'd2, 16'h0001);
            collect_stream(s.count, s.rand_ready, s.host_reads, mem_addr_t'(s.addr));
         end
         STREAM_STOP: stop_stream();
         default:     stop_on_error("unknown step kind in the test table");
      endcase
   endtask

   //--------------------
   // step table
   //--------------------
   task automatic fill_table();
      // kind, addr, wdata, rand, byte_en, exp, count, rand_ready, host_reads
      for (int w = 0; w < 4; w++) begin
         steps[w]     = '{HOST_WR, 16'(16 + w), 32'h0, 1'b1, 4'hf, 16'h0, 16'd0, 1'b0, 1'b0};
         steps[w + 4] = '{HOST_WR, 16'(24 + w), 32'h0, 1'b1, 4'hf, 16'h0, 16'd0, 1'b0, 1'b0};
      end
      steps[8]  = '{HOST_WR, 16'd100, 32'h0, 1'b1, 4'hf, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[9]  = '{HOST_WR, 16'd100, 32'h0, 1'b1, 4'h5, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[10] = '{HOST_RD, 16'd100, 32'h0, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[11] = '{HOST_WR, 16'd101, 32'h0, 1'b1, 4'hf, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[12] = '{HOST_WR, 16'd101, 32'h0, 1'b1, 4'h8, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[13] = '{HOST_WR, 16'd101, 32'h12345678, 1'b0, 4'h3, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[14] = '{HOST_RD, 16'd101, 32'h0, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[15] = '{HOST_WR, 16'd102, 32'h0, 1'b1, 4'hf, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[16] = '{HOST_WR, 16'd102, 32'hdeadbeef, 1'b0, 4'h6, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[17] = '{HOST_RD, 16'd102, 32'h0, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[18] = '{HOST_RD, 16'd16, 32'h0, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[19] = '{REG_WR, 16'd0, 32'hf010, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};  // top bits drop
      steps[20] = '{REG_RD, 16'd0, 32'h0, 1'b0, 4'h0, 16'h0010, 16'd0, 1'b0, 1'b0};
      steps[21] = '{REG_WR, 16'd1, 32'h0013, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[22] = '{REG_RD, 16'd1, 32'h0, 1'b0, 4'h0, 16'h0013, 16'd0, 1'b0, 1'b0};
      steps[23] = '{REG_WR, 16'd2, 32'h0001, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[24] = '{REG_RD, 16'd3, 32'h0, 1'b0, 4'h0, 16'h0001, 16'd0, 1'b0, 1'b0};  // alias
      steps[25] = '{REG_WR, 16'd2, 32'h0000, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[26] = '{REG_RD, 16'd2, 32'h0, 1'b0, 4'h0, 16'h0000, 16'd0, 1'b0, 1'b0};
      steps[27] = '{STREAM_RUN, 16'd0, 32'h0, 1'b0, 4'h0, 16'h0, 16'd40, 1'b0, 1'b0};
      steps[28] = '{STREAM_RUN, 16'd100, 32'h0, 1'b0, 4'h0, 16'h0, 16'd48, 1'b1, 1'b1};
      steps[29] = '{STREAM_STOP, 16'd0, 32'h0, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[30] = '{REG_WR, 16'd0, 32'h0018, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[31] = '{REG_WR, 16'd1, 32'h001b, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
      steps[32] = '{REG_RD, 16'd0, 32'h0, 1'b0, 4'h0, 16'h0018, 16'd0, 1'b0, 1'b0};
      steps[33] = '{STREAM_RUN, 16'd100, 32'h0, 1'b0, 4'h0, 16'h0, 16'd12, 1'b0, 1'b1};
      steps[34] = '{STREAM_STOP, 16'd0, 32'h0, 1'b0, 4'h0, 16'h0, 16'd0, 1'b0, 1'b0};
   endtask

   //--------------------
   // main sequence
   //--------------------
   initial begin
      host         = '0;
      regs         = '0;
      stream_ready = 1'b0;
      model_start  = '0;
      model_stop   = '0;
      model_run    = 1'b0;
      stream_index = 0;
      lfsr_state   = 32'hed8a134b;
      fill_table();
      wait (reset_n === 1'b1);
      repeat (4) begin  // outputs quiet with no stimulus
         @(negedge clk);
         if (stream.valid !== 1'b0 || host_rsp.rd_done !== 1'b0 || reg_rvalid !== 1'b0) begin
            stop_on_error("a valid or done output was not low after reset");
         end
      end
      for (int i = 0; i < NUM_STEPS; i++) begin
         run_step(steps[i]);
      end
      repeat (2) @(negedge clk);
      $display("All checks passed");
      $finish;
   end

   // hard limit on the whole run
   initial begin
      #(WATCHDOG_NS);
      stop_on_error($sformatf("run timed out after %0d ns before the step table finished",
                              WATCHDOG_NS));
   end

endmodule

// ==== sim.f ====
+incdir+include
logic/stream_mem_pkg.sv
logic/stream_regs.sv
logic/mem_arbiter.sv
logic/byte_streamer.sv
logic/stream_mem_top.sv
testbench/tb_clock.sv
testbench/stream_mem_tb.sv

// ==== Bender.yml ====
package:
  name: stream_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/stream_mem_pkg.sv
      - logic/stream_regs.sv
      - logic/mem_arbiter.sv
      - logic/byte_streamer.sv
      - logic/stream_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clock.sv
      - testbench/stream_mem_tb.sv
